// ==== sim.f ====
source/mbus_rx_pkg.sv
source/rx_ctrl_if.sv
source/mbus_clk_divider.sv
source/short_addr_register.sv
source/rx_sequencer.sv
source/rx_word_shifter.sv
source/rx_frame_formatter.sv
source/mbus_rx_layer.sv
bench/mbus_ctrl_model.sv
bench/tb_mbus_rx_layer.sv

// ==== Bender.yml ====
package:
  name: mbus_rx_layer

sources:
  - files:
      - source/mbus_rx_pkg.sv
      - source/rx_ctrl_if.sv
      - source/mbus_clk_divider.sv
      - source/short_addr_register.sv
      - source/rx_sequencer.sv
      - source/rx_word_shifter.sv
      - source/rx_frame_formatter.sv
      - source/mbus_rx_layer.sv
  - target: test
    files:
      - bench/mbus_ctrl_model.sv
      - bench/tb_mbus_rx_layer.sv

// ==== bench/tb_mbus_rx_layer.sv ====
`timescale 1ns/1ps

module tb_mbus_rx_layer
	import mbus_rx_pkg::*;
();

	localparam int CLK_DIV_W   = 22;
	localparam int DRIVE_DELAY = 2;
	localparam int TIMEOUT     = 400;

	logic                    clk;
	logic                    reset;
	logic [CLK_DIV_W-1:0]    clk_div;
	logic [SHORT_ADDR_W-1:0] short_addr_override;
	logic [BYTE_W-1:0]       time_tag;
	logic [WORD_W-1:0]       rx_addr;
	logic [WORD_W-1:0]       rx_data;
	logic                    rx_req;
	logic                    rx_fail;
	logic                    rx_pend;
	logic                    rx_broadcast;
	logic [CTRL_W-1:0]       ctrl_bits;
	logic                    addr_write;
	logic [SHORT_ADDR_W-1:0] addr_value;
	logic                    addr_invalid_n;
	logic                    mbus_clk;
	logic [SHORT_ADDR_W-1:0] assigned_addr;
	logic                    assigned_addr_valid;
	logic                    rx_ack;
	logic                    frame_valid;
	logic [BYTE_W-1:0]       frame_byte;
	logic                    byte_valid;
	logic                    incr_time;

	logic [BYTE_W-1:0] frame_bytes[$];
	int                ack_count;
	int                incr_count;
	int                len;
	bit                ok;

	mbus_rx_layer #(.CLK_DIV_W(CLK_DIV_W)) UUT (.*);

	mbus_ctrl_model #(.DRIVE_DELAY(DRIVE_DELAY), .TIMEOUT(TIMEOUT)) ctrl (.*);

	always #20 clk = ~clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic compare_value(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERR %s: expected %0h, actual %0h", test, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// outside time counter, advanced by incr_time
	always @(negedge clk) begin
		if (!reset && incr_time) begin
			@(posedge clk);
			#DRIVE_DELAY;
			time_tag = time_tag + 8'd1;
		end
	end

	always @(negedge clk) begin
		if (!reset)
			assert (frame_valid || !byte_valid) else fail_run("byte_valid outside frame_valid");
	end

	// length of the current mbus_clk phase in clk cycles
	task automatic measure_run(input logic level, output int run);
		run = 0;
		while (mbus_clk === level && run < TIMEOUT) begin
			run++;
			@(negedge clk);
		end
	endtask

	// override reads as valid 5 whatever the register holds
	task automatic check_override(input string test);
		@(posedge clk);
		#DRIVE_DELAY;
		short_addr_override = 4'h5;
		@(negedge clk);
		compare_value(test, 4'h5, assigned_addr);
		compare_value({test, " valid"}, 1, assigned_addr_valid);
		@(posedge clk);
		#DRIVE_DELAY;
		short_addr_override = 4'hF;
	endtask

	task automatic collect_frame(input int bytes);
		int cycles;
		frame_bytes.delete();
		ack_count  = 0;
		incr_count = 0;
		cycles     = 0;
		while (frame_bytes.size() < bytes && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (rx_ack)
				ack_count++;
			if (incr_time) begin
				incr_count++;
				compare_value("incr_time on time byte", 1, frame_bytes.size());
			end
			if (byte_valid && frame_valid)
				frame_bytes.push_back(frame_byte);
		end
		assert (frame_bytes.size() == bytes) else fail_run("frame did not complete in time");
		@(negedge clk);
		compare_value("frame_valid after status byte", 0, frame_valid);
	endtask

	task automatic run_message(input string test, input int words);
		logic [BYTE_W-1:0] expected[$];
		logic [BYTE_W-1:0] tag;
		bit                sent;
		int                i;
		tag = time_tag;
		fork
			ctrl.send_message(words, sent);
			collect_frame(4 * words + 7);
		join
		assert (sent) else fail_run("controller model got no rx_ack for a word");
		expected.push_back(8'h62);
		expected.push_back(tag);
		for (i = 0; i < ctrl.exp_payload.size(); i++)
			expected.push_back(ctrl.exp_payload[i]);
		expected.push_back(ctrl.exp_status);
		compare_value({test, " length"}, expected.size(), frame_bytes.size());
		for (i = 0; i < expected.size(); i++)
			compare_value($sformatf("%s byte %0d", test, i), expected[i], frame_bytes[i]);
		compare_value({test, " acks"}, words, ack_count);
		compare_value({test, " incr_time"}, 1, incr_count);
	endtask

	task automatic run_failure();
		bit acked;
		int run;
		int cycles;
		fork
			ctrl.issue_failure(acked);
			begin
				cycles = 0;
				run    = 0;
				while (!rx_ack && cycles < TIMEOUT) begin
					@(negedge clk);
					cycles++;
					compare_value("failure frame_valid", 0, frame_valid);
				end
				while (rx_ack && run < TIMEOUT) begin
					run++;
					@(negedge clk);
					compare_value("failure frame_valid", 0, frame_valid);
				end
				compare_value("failure ack length", 3, run);
				repeat (10) begin
					@(negedge clk);
					compare_value("failure frame_valid", 0, frame_valid);
				end
			end
		join
		assert (acked) else fail_run("no rx_ack after rx_fail");
	endtask

	initial begin
		clk                 = 1'b0;
		reset               = 1'b1;
		clk_div             = 3;
		short_addr_override = 4'hF;
		time_tag            = 8'h5a;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		// divider, 4 cycles per phase
		@(negedge clk);
		compare_value("divider after reset", 0, mbus_clk);
		measure_run(1'b0, len);
		repeat (2) begin
			measure_run(1'b1, len);
			compare_value("divider high phase", 4, len);
			measure_run(1'b0, len);
			compare_value("divider low phase", 4, len);
		end

		compare_value("addr after reset", 4'hF, assigned_addr);
		compare_value("addr valid after reset", 0, assigned_addr_valid);
		ctrl.update_addr(1'b1, 4'hA, ok);
		assert (ok) else fail_run("no mbus_clk rise during the address write");
		@(negedge clk);
		compare_value("addr write", 4'hA, assigned_addr);
		compare_value("addr write valid", 1, assigned_addr_valid);
		check_override("addr override on valid register");
		ctrl.update_addr(1'b0, 4'h0, ok);
		assert (ok) else fail_run("no mbus_clk rise during the address invalidation");
		@(negedge clk);
		compare_value("addr invalidate", 4'hF, assigned_addr);
		compare_value("addr invalidate valid", 0, assigned_addr_valid);
		check_override("addr override on invalid register");

		run_message("single word", 1);
		run_message("multi word", 3);
		run_failure();
		run_message("after failure", 2);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== bench/mbus_ctrl_model.sv ====
`timescale 1ns/1ps

module mbus_ctrl_model
	import mbus_rx_pkg::*;
#(
	parameter int DRIVE_DELAY = 2,
	parameter int TIMEOUT     = 400
) (
	input  logic                    clk,
	input  logic                    rx_ack,
	input  logic                    mbus_clk,
	output logic [WORD_W-1:0]       rx_addr,
	output logic [WORD_W-1:0]       rx_data,
	output logic                    rx_req,
	output logic                    rx_fail,
	output logic                    rx_pend,
	output logic                    rx_broadcast,
	output logic [CTRL_W-1:0]       ctrl_bits,
	output logic                    addr_write,
	output logic [SHORT_ADDR_W-1:0] addr_value,
	output logic                    addr_invalid_n
);

	integer            seed;
	// payload bytes and status of the last message sent
	logic [BYTE_W-1:0] exp_payload[$];
	logic [BYTE_W-1:0] exp_status;

	initial begin
		seed           = 32'h3f73_fdb2;
		rx_addr        = '0;
		rx_data        = '0;
		rx_req         = 1'b0;
		rx_fail        = 1'b0;
		rx_pend        = 1'b0;
		rx_broadcast   = 1'b0;
		ctrl_bits      = '0;
		addr_write     = 1'b0;
		addr_value     = '0;
		addr_invalid_n = 1'b1;
		exp_status     = '0;
	end

	// rx_ack sampled mid-cycle
	task automatic wait_ack(output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < TIMEOUT && !ok; n++) begin
			@(negedge clk);
			ok = rx_ack;
		end
	endtask

	task automatic send_word(input bit first, input bit last, output bit ok);
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] data;
		logic              bcast;
		logic [CTRL_W-1:0] ctrl;
		int                i;
		addr  = $random(seed);
		data  = $random(seed);
		bcast = $random(seed);
		ctrl  = $random(seed);
		@(posedge clk);
		#DRIVE_DELAY;
		rx_addr      = addr;
		rx_data      = data;
		rx_broadcast = bcast;
		ctrl_bits    = ctrl;
		rx_pend      = !last;
		rx_req       = 1'b1;
		// address goes out only with the first word, msb first
		for (i = WORD_W - BYTE_W; i >= 0 && first; i -= BYTE_W)
			exp_payload.push_back(addr[i +: BYTE_W]);
		for (i = WORD_W - BYTE_W; i >= 0; i -= BYTE_W)
			exp_payload.push_back(data[i +: BYTE_W]);
		exp_status |= {4'b0000, 1'b0, bcast, ctrl};
		wait_ack(ok);
		@(posedge clk);
		#DRIVE_DELAY;
		rx_req = 1'b0;
		// let the low request pass the synchronizer
		repeat (2) @(posedge clk);
	endtask

	task automatic send_message(input int words, output bit ok);
		int w;
		ok = 1'b1;
		exp_payload.delete();
		exp_status = '0;
		for (w = 0; w < words && ok; w++)
			send_word(w == 0, w == words - 1, ok);
	endtask

	task automatic issue_failure(output bit ok);
		@(posedge clk);
		#DRIVE_DELAY;
		rx_fail = 1'b1;
		wait_ack(ok);
		@(posedge clk);
		#DRIVE_DELAY;
		rx_fail = 1'b0;
		repeat (4) @(posedge clk);
	endtask

	// a real low-to-high edge of mbus_clk
	task automatic wait_mbus_rise(output bit ok);
		bit seen_low;
		int n;
		ok       = 1'b0;
		seen_low = 1'b0;
		for (n = 0; n < TIMEOUT && !ok; n++) begin
			@(negedge clk);
			ok       = seen_low && mbus_clk;
			seen_low = seen_low || !mbus_clk;
		end
	endtask

	// write a new address, or invalidate when write is low
	task automatic update_addr(input bit write, input logic [SHORT_ADDR_W-1:0] value,
			output bit ok);
		@(posedge clk);
		#DRIVE_DELAY;
		addr_write     = write;
		addr_value     = value;
		addr_invalid_n = write;
		wait_mbus_rise(ok);
		@(posedge clk);
		#DRIVE_DELAY;
		addr_write     = 1'b0;
		addr_invalid_n = 1'b1;
	endtask

endmodule

// ==== source/mbus_rx_layer.sv ====
`timescale 1ns/1ps

module mbus_rx_layer
	import mbus_rx_pkg::*;
#(
	parameter int CLK_DIV_W = 22
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [CLK_DIV_W-1:0]    clk_div,
	input  logic [SHORT_ADDR_W-1:0] short_addr_override,
	input  logic [WORD_W-1:0]       rx_addr,
	input  logic [WORD_W-1:0]       rx_data,
	input  logic                    rx_req,
	input  logic                    rx_fail,
	input  logic                    rx_pend,
	input  logic                    rx_broadcast,
	input  logic [CTRL_W-1:0]       ctrl_bits,
	input  logic                    addr_write,
	input  logic [SHORT_ADDR_W-1:0] addr_value,
	input  logic                    addr_invalid_n,
	input  logic [BYTE_W-1:0]       time_tag,
	output logic                    mbus_clk,
	output logic [SHORT_ADDR_W-1:0] assigned_addr,
	output logic                    assigned_addr_valid,
	output logic                    rx_ack,
	output logic                    frame_valid,
	output logic [BYTE_W-1:0]       frame_byte,
	output logic                    byte_valid,
	output logic                    incr_time
);

	logic              mbus_clk_rise;
	logic [BYTE_W-1:0] data_byte;

	rx_ctrl_if ctl ();

	mbus_clk_divider #(
		.CLK_DIV_W(CLK_DIV_W)
	) u_clk_div (
		.clk          (clk),
		.reset        (reset),
		.clk_div      (clk_div),
		.mbus_clk     (mbus_clk),
		.mbus_clk_rise(mbus_clk_rise)
	);

	short_addr_register u_short_addr (
		.clk                (clk),
		.reset              (reset),
		.mbus_clk_rise      (mbus_clk_rise),
		.short_addr_override(short_addr_override),
		.addr_write         (addr_write),
		.addr_value         (addr_value),
		.addr_invalid_n     (addr_invalid_n),
		.assigned_addr      (assigned_addr),
		.assigned_addr_valid(assigned_addr_valid)
	);

	rx_sequencer u_seq (
		.clk        (clk),
		.reset      (reset),
		.rx_req     (rx_req),
		.rx_fail    (rx_fail),
		.rx_pend    (rx_pend),
		.ctl        (ctl.seq),
		.rx_ack     (rx_ack),
		.frame_valid(frame_valid),
		.byte_valid (byte_valid),
		.incr_time  (incr_time)
	);

	rx_word_shifter u_shifter (
		.clk      (clk),
		.reset    (reset),
		.rx_addr  (rx_addr),
		.rx_data  (rx_data),
		.ctl      (ctl.shifter),
		.data_byte(data_byte)
	);

	rx_frame_formatter u_formatter (
		.clk         (clk),
		.reset       (reset),
		.rx_fail     (rx_fail),
		.rx_broadcast(rx_broadcast),
		.ctrl_bits   (ctrl_bits),
		.time_tag    (time_tag),
		.data_byte   (data_byte),
		.ctl         (ctl.formatter),
		.frame_byte  (frame_byte)
	);

endmodule

// ==== source/rx_frame_formatter.sv ====
`timescale 1ns/1ps

module rx_frame_formatter
	import mbus_rx_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              rx_fail,
	input  logic              rx_broadcast,
	input  logic [CTRL_W-1:0] ctrl_bits,
	input  logic [BYTE_W-1:0] time_tag,
	input  logic [BYTE_W-1:0] data_byte,
	rx_ctrl_if.formatter      ctl,
	output logic [BYTE_W-1:0] frame_byte
);

	logic [BYTE_W-1:0] status;
	logic [BYTE_W-1:0] word_status;

	// status bits of the word being loaded
	always_comb begin
		word_status                                        = '0;
		word_status[STATUS_FAIL_BIT]                       = rx_fail;
		word_status[STATUS_BCAST_BIT]                      = rx_broadcast;
		word_status[STATUS_CTRL_LSB +: CTRL_W]             = ctrl_bits;
	end

	// sticky across all words of one message
	always_ff @(posedge clk) begin
		if (reset || ctl.start_frame)
			status <= '0;
		else if (ctl.load_word)
			status <= status | word_status;
	end

	always_comb begin
		if (ctl.sel_flag)
			frame_byte = FRAME_FLAG;
		else if (ctl.sel_time)
			frame_byte = time_tag;
		else if (ctl.sel_status)
			frame_byte = status;
		else
			frame_byte = data_byte;
	end

endmodule

// ==== source/rx_word_shifter.sv ====
`timescale 1ns/1ps

module rx_word_shifter
	import mbus_rx_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic [WORD_W-1:0] rx_addr,
	input  logic [WORD_W-1:0] rx_data,
	rx_ctrl_if.shifter        ctl,
	output logic [BYTE_W-1:0] data_byte
);

	localparam int SR_W = 2 * WORD_W;

	logic [SR_W-1:0] data_sr;
	logic [3:0]      byte_cnt;
	logic            first_word;

	// load a word, then move the next byte to the top
	always_ff @(posedge clk) begin
		if (ctl.load_word) begin
			if (first_word)
				data_sr <= {rx_addr, rx_data};
			else
				data_sr <= {rx_data, {WORD_W{1'b0}}};
		end else if (ctl.shift_byte) begin
			data_sr <= {data_sr[SR_W-BYTE_W-1:0], {BYTE_W{1'b0}}};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			byte_cnt   <= '0;
			first_word <= 1'b1;
		end else begin
			if (ctl.start_frame)
				first_word <= 1'b1;
			else if (ctl.load_word)
				first_word <= 1'b0;
			// address and data on the first word, data only afterwards
			if (ctl.load_word)
				byte_cnt <= first_word ? 4'd8 : 4'd4;
			else if (ctl.shift_byte && byte_cnt != 4'd0)
				byte_cnt <= byte_cnt - 4'd1;
		end
	end

	// msb first
	assign data_byte      = data_sr[SR_W-1 -: BYTE_W];
	assign ctl.word_empty = (byte_cnt == 4'd1);

endmodule

// ==== source/rx_sequencer.sv ====
`timescale 1ns/1ps

module rx_sequencer
	import mbus_rx_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   rx_req,
	input  logic   rx_fail,
	input  logic   rx_pend,
	rx_ctrl_if.seq ctl,
	output logic   rx_ack,
	output logic   frame_valid,
	output logic   byte_valid,
	output logic   incr_time
);

	rx_state_t  state;
	rx_state_t  next_state;
	logic [1:0] req_sync;
	logic [1:0] fail_sync;
	logic       req_s;
	logic       fail_s;
	logic       req_armed;
	logic       fail_armed;
	logic       pend_q;
	logic [1:0] state_cnt;
	logic       time_done;
	logic       fail_done;

	assign req_s     = req_sync[1];
	assign fail_s    = fail_sync[1];
	assign time_done = (state_cnt == 2'd1);
	assign fail_done = (state_cnt == 2'(FAIL_ACK_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= IDLE;
			state_cnt  <= '0;
			req_sync   <= '0;
			fail_sync  <= '0;
			req_armed  <= 1'b0;
			fail_armed <= 1'b0;
			pend_q     <= 1'b0;
			rx_ack     <= 1'b0;
		end else begin
			req_sync  <= {req_sync[0], rx_req};
			fail_sync <= {fail_sync[0], rx_fail};
			state     <= next_state;
			if (next_state != state)
				state_cnt <= '0;
			else
				state_cnt <= state_cnt + 2'd1;
			// ack one cycle after each load, and through the failure ack
			rx_ack <= ctl.load_word || (state == FAIL_ACK);
			if (ctl.load_word)
				pend_q <= rx_pend;
			// a request counts only once it was seen low after its ack
			if (ctl.load_word)
				req_armed <= 1'b0;
			else if (!req_s)
				req_armed <= 1'b1;
			if (state == FAIL_ACK)
				fail_armed <= 1'b0;
			else if (!fail_s)
				fail_armed <= 1'b1;
		end
	end

	always_comb begin
		next_state      = state;
		ctl.start_frame = 1'b0;
		ctl.load_word   = 1'b0;
		ctl.shift_byte  = 1'b0;
		ctl.sel_flag    = 1'b0;
		ctl.sel_time    = 1'b0;
		ctl.sel_status  = 1'b0;
		frame_valid     = 1'b0;
		byte_valid      = 1'b0;
		incr_time       = 1'b0;
		case (state)
			IDLE: begin
				ctl.start_frame = 1'b1;
				if (req_s && req_armed)
					next_state = HDR_FLAG;
				else if (fail_s && fail_armed)
					next_state = FAIL_ACK;
			end
			HDR_FLAG: begin
				ctl.sel_flag = 1'b1;
				frame_valid  = 1'b1;
				byte_valid   = 1'b1;
				next_state   = HDR_TIME;
			end
			HDR_TIME: begin
				ctl.sel_time = 1'b1;
				frame_valid  = 1'b1;
				// time tag is taken on the second cycle
				if (time_done) begin
					byte_valid = 1'b1;
					incr_time  = 1'b1;
					next_state = RX_LOAD;
				end
			end
			RX_LOAD: begin
				ctl.load_word = 1'b1;
				next_state    = RX_SHIFT;
			end
			RX_SHIFT: begin
				ctl.shift_byte = 1'b1;
				frame_valid    = 1'b1;
				byte_valid     = 1'b1;
				if (ctl.word_empty)
					next_state = RX_CHECK;
			end
			RX_CHECK: begin
				if (!pend_q)
					next_state = RX_END;
				else if (req_s && req_armed)
					next_state = RX_LOAD;
			end
			RX_END: begin
				ctl.sel_status = 1'b1;
				frame_valid    = 1'b1;
				byte_valid     = 1'b1;
				next_state     = IDLE;
			end
			FAIL_ACK: begin
				if (fail_done)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

endmodule

// ==== source/short_addr_register.sv ====
`timescale 1ns/1ps

module short_addr_register
	import mbus_rx_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    mbus_clk_rise,
	input  logic [SHORT_ADDR_W-1:0] short_addr_override,
	input  logic                    addr_write,
	input  logic [SHORT_ADDR_W-1:0] addr_value,
	input  logic                    addr_invalid_n,
	output logic [SHORT_ADDR_W-1:0] assigned_addr,
	output logic                    assigned_addr_valid
);

	// address as written by the controller
	logic [SHORT_ADDR_W-1:0] reg_addr;
	logic                    reg_valid;

	// controller side only moves on mbus clock rising edges
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_addr  <= SHORT_ADDR_NONE;
			reg_valid <= 1'b0;
		end else if (mbus_clk_rise) begin
			if (addr_write) begin
				reg_addr  <= addr_value;
				reg_valid <= 1'b1;
			end else if (!addr_invalid_n) begin
				reg_addr  <= SHORT_ADDR_NONE;
				reg_valid <= 1'b0;
			end
		end
	end

	// user override wins
	always_comb begin
		if (short_addr_override != SHORT_ADDR_NONE) begin
			assigned_addr       = short_addr_override;
			assigned_addr_valid = 1'b1;
		end else begin
			assigned_addr       = reg_addr;
			assigned_addr_valid = reg_valid;
		end
	end

endmodule

// ==== source/mbus_clk_divider.sv ====
`timescale 1ns/1ps

module mbus_clk_divider #(
	parameter int CLK_DIV_W = 22
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [CLK_DIV_W-1:0] clk_div,
	output logic                 mbus_clk,
	output logic                 mbus_clk_rise
);

	logic [CLK_DIV_W-1:0] div_cnt;
	logic                 div_hit;

	assign div_hit = (div_cnt == clk_div);

	// half period is clk_div+1 cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt       <= '0;
			mbus_clk      <= 1'b0;
			mbus_clk_rise <= 1'b0;
		end else begin
			mbus_clk_rise <= div_hit && !mbus_clk;
			if (div_hit) begin
				div_cnt  <= '0;
				mbus_clk <= ~mbus_clk;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== source/rx_ctrl_if.sv ====
`timescale 1ns/1ps

interface rx_ctrl_if;

	// commands from the sequencer
	logic start_frame;
	logic load_word;
	logic shift_byte;
	logic sel_flag;
	logic sel_time;
	logic sel_status;

	// last byte of the loaded word goes out this cycle
	logic word_empty;

	modport seq (
		output start_frame,
		output load_word,
		output shift_byte,
		output sel_flag,
		output sel_time,
		output sel_status,
		input  word_empty
	);

	modport shifter (
		input  start_frame,
		input  load_word,
		input  shift_byte,
		output word_empty
	);

	modport formatter (
		input start_frame,
		input load_word,
		input sel_flag,
		input sel_time,
		input sel_status
	);

endinterface

// ==== source/mbus_rx_pkg.sv ====
package mbus_rx_pkg;

	// receive sequencer states
	typedef enum logic [2:0] {
		IDLE,
		HDR_FLAG,
		HDR_TIME,
		RX_LOAD,
		RX_SHIFT,
		RX_CHECK,
		RX_END,
		FAIL_ACK
	} rx_state_t;

	localparam int BYTE_W       = 8;
	localparam int WORD_W       = 32;
	localparam int SHORT_ADDR_W = 4;
	localparam int CTRL_W       = 2;

	// override "none" and also the invalidated register value
	localparam logic [SHORT_ADDR_W-1:0] SHORT_ADDR_NONE = 4'hF;

	// first byte of every frame
	localparam logic [BYTE_W-1:0] FRAME_FLAG = 8'h62;

	// status byte layout, upper nibble stays zero
	localparam int STATUS_FAIL_BIT  = 3;
	localparam int STATUS_BCAST_BIT = 2;
	localparam int STATUS_CTRL_LSB  = 0;

	// ack length after a failure outside a message
	localparam int FAIL_ACK_CYCLES = 3;

endpackage
